/* common/uart_pkg.sv */
/*
 * Serial byte layer definitions
 * Byte type, bit timing and counter widths shared by the 8N1 engines
 */
package uart_pkg;

	// One data byte on the line
	typedef logic [7:0] byte_t;

	// sys_clk cycles per bit, and half of it for the start-bit check
	localparam int CLKS_PER_BIT = 16;
	localparam int HALF_BIT     = CLKS_PER_BIT / 2;

	// Start bit, eight data bits and one stop bit
	localparam int FRAME_BITS = 10;

	// Counts cycles within one bit period
	typedef logic [4:0] baud_cnt_t;

	// Position of the current bit inside the 10-bit character
	typedef logic [3:0] bit_idx_t;

endpackage

/* common/frame_pkg.sv */
/*
 * String framing layer definitions
 * Payload limits, packed string layout, the frame marker and the framer states
 */
package frame_pkg;

	// Longest payload carried in one frame
	localparam int MAX_LEN = 16;

	// Payload length, 0 to MAX_LEN
	typedef logic [4:0] len_t;

	// Byte i sits at bits 8i+7 down to 8i
	typedef logic [8*MAX_LEN-1:0] str_t;

	localparam uart_pkg::byte_t MARK = 8'h26;	// The '&' character

	// Transmit framer: two opening markers, payload, two closing markers
	typedef enum logic [2:0] {
		TX_IDLE,
		TX_OPEN1,
		TX_OPEN2,
		TX_BODY,
		TX_CLOSE1,
		TX_CLOSE2
	} tx_state_t;

	// Receive framer
	typedef enum logic [1:0] {
		RX_HUNT,	// Waiting for a first marker
		RX_OPEN,	// One marker seen
		RX_BODY,	// Collecting payload
		RX_CLOSE	// One marker seen inside the body
	} rx_state_t;

endpackage

/* common/uart_byte_if.sv */
/*
 * Byte link between the string framers and the serial engines
 * Transmit side uses a request and done strobe, receive side a valid strobe
 */
`timescale 1ns/100ps

interface uart_byte_if;

	uart_pkg::byte_t tx_data;
	logic            tx_req;	// One-cycle request, tx_data valid with it
	logic            tx_done;	// One cycle after the stop bit ends
	uart_pkg::byte_t rx_data;
	logic            rx_vld;	// One cycle at the middle of the stop bit

	modport framer_tx (output tx_data, output tx_req, input tx_done);
	modport ser_tx    (input tx_data, input tx_req, output tx_done);
	modport framer_rx (input rx_data, input rx_vld);
	modport ser_rx    (output rx_data, output rx_vld);

endinterface

/* hw/uart/uart_tx.sv */
/*
 * 8N1 serial byte transmitter
 * Shifts start bit, data LSB first and stop bit out of a 10-bit register
 */
`timescale 1ns/100ps

module uart_tx (
	input  logic        sys_clk,
	input  logic        sys_rst_n,
	uart_byte_if.ser_tx bus,
	output logic        txd
);

	logic                                  busy;
	logic                                  bit_end;
	uart_pkg::bit_idx_t                    bit_idx;
	uart_pkg::baud_cnt_t                   baud_cnt;
	logic [uart_pkg::FRAME_BITS-1:0]       shreg;

	assign bit_end = (baud_cnt == uart_pkg::baud_cnt_t'(uart_pkg::CLKS_PER_BIT - 1));

	// The register refills with ones as it shifts, so the line idles high
	assign txd = shreg[0];

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy        <= 1'b0;
			bit_idx     <= '0;
			baud_cnt    <= '0;
			shreg       <= '1;
			bus.tx_done <= 1'b0;
		end else begin
			bus.tx_done <= 1'b0;
			if (!busy) begin
				if (bus.tx_req) begin	// A request while busy is not possible by protocol
					busy     <= 1'b1;
					bit_idx  <= '0;
					baud_cnt <= '0;
					shreg    <= {1'b1, bus.tx_data, 1'b0};
				end
			end else if (bit_end) begin
				baud_cnt <= '0;
				shreg    <= {1'b1, shreg[uart_pkg::FRAME_BITS-1:1]};
				if (bit_idx == uart_pkg::bit_idx_t'(uart_pkg::FRAME_BITS - 1)) begin
					// Last cycle of the stop bit
					busy        <= 1'b0;
					bus.tx_done <= 1'b1;
				end else begin
					bit_idx <= bit_idx + 1'b1;
				end
			end else begin
				baud_cnt <= baud_cnt + 1'b1;
			end
		end
	end

endmodule

/* hw/uart/uart_rx.sv */
/*
 * 8N1 serial byte receiver
 * Synchronizes the line, confirms the start bit at mid-bit and samples each bit
 * in its middle. A byte with a low stop bit is dropped
 */
`timescale 1ns/100ps

module uart_rx (
	input  logic        sys_clk,
	input  logic        sys_rst_n,
	input  logic        rxd,
	uart_byte_if.ser_rx bus
);

	logic                rxd_meta;
	logic                rxd_sync;
	logic                rxd_prev;
	logic                busy;
	logic                sample;
	uart_pkg::bit_idx_t  bit_idx;
	uart_pkg::baud_cnt_t baud_cnt;
	uart_pkg::byte_t     shreg;

	// Start bit is checked after half a bit, every later bit one full bit on
	assign sample = busy && (baud_cnt == ((bit_idx == '0) ?
		uart_pkg::baud_cnt_t'(uart_pkg::HALF_BIT - 1) :
		uart_pkg::baud_cnt_t'(uart_pkg::CLKS_PER_BIT - 1)));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			rxd_prev <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			rxd_prev <= rxd_sync;	// Kept for falling edge detection
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy       <= 1'b0;
			bit_idx    <= '0;
			baud_cnt   <= '0;
			bus.rx_vld <= 1'b0;
		end else begin
			bus.rx_vld <= 1'b0;
			if (!busy) begin
				if (rxd_prev && !rxd_sync) begin
					busy     <= 1'b1;
					bit_idx  <= '0;
					baud_cnt <= '0;
				end
			end else if (sample) begin
				baud_cnt <= '0;
				if (bit_idx == '0) begin
					if (rxd_sync)
						busy <= 1'b0;	// Glitch, not a real start bit
					else
						bit_idx <= 4'd1;
				end else if (bit_idx == uart_pkg::bit_idx_t'(uart_pkg::FRAME_BITS - 1)) begin
					busy       <= 1'b0;
					bus.rx_vld <= rxd_sync;
				end else begin
					bit_idx <= bit_idx + 1'b1;
				end
			end else begin
				baud_cnt <= baud_cnt + 1'b1;
			end
		end
	end

	// Data bits arrive LSB first
	always_ff @(posedge sys_clk) begin
		if (sample && bit_idx != '0 && bit_idx != uart_pkg::bit_idx_t'(uart_pkg::FRAME_BITS - 1))
			shreg <= {rxd_sync, shreg[7:1]};
		if (sample && bit_idx == uart_pkg::bit_idx_t'(uart_pkg::FRAME_BITS - 1))
			bus.rx_data <= shreg;
	end

endmodule

/* hw/frame/frame_tx.sv */
/*
 * Transmit string framer
 * Sends two '&' markers, the payload bytes and two closing markers, one byte
 * request per completed byte, and pulses done after the last marker
 */
`timescale 1ns/100ps

module frame_tx (
	input  logic            sys_clk,
	input  logic            sys_rst_n,
	input  logic            req,
	input  frame_pkg::str_t str,
	input  frame_pkg::len_t length,
	output logic            busy,
	output logic            done,
	uart_byte_if.framer_tx  bus
);

	frame_pkg::tx_state_t state;
	frame_pkg::tx_state_t state_nxt;
	frame_pkg::str_t      str_q;
	frame_pkg::len_t      len_q;
	frame_pkg::len_t      idx;	// Next payload byte to send
	logic                 start;
	logic                 send;
	logic                 send_pay;
	uart_pkg::byte_t      send_data;

	assign start     = (state == frame_pkg::TX_IDLE) && req;
	assign busy      = (state != frame_pkg::TX_IDLE);
	assign send_data = send_pay ? str_q[{idx[3:0], 3'b000} +: 8] : frame_pkg::MARK;

	always_comb begin
		state_nxt = state;
		send      = 1'b0;
		send_pay  = 1'b0;
		case (state)
			frame_pkg::TX_IDLE: if (req) begin
				state_nxt = frame_pkg::TX_OPEN1;
				send      = 1'b1;
			end
			frame_pkg::TX_OPEN1: if (bus.tx_done) begin
				state_nxt = frame_pkg::TX_OPEN2;
				send      = 1'b1;
			end
			// An empty payload falls straight through to the closing markers
			frame_pkg::TX_OPEN2, frame_pkg::TX_BODY: if (bus.tx_done) begin
				send = 1'b1;
				if (idx != len_q) begin
					state_nxt = frame_pkg::TX_BODY;
					send_pay  = 1'b1;
				end else begin
					state_nxt = frame_pkg::TX_CLOSE1;
				end
			end
			frame_pkg::TX_CLOSE1: if (bus.tx_done) begin
				state_nxt = frame_pkg::TX_CLOSE2;
				send      = 1'b1;
			end
			frame_pkg::TX_CLOSE2: if (bus.tx_done)
				state_nxt = frame_pkg::TX_IDLE;
			default: state_nxt = frame_pkg::TX_IDLE;
		endcase
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state      <= frame_pkg::TX_IDLE;
			idx        <= '0;
			bus.tx_req <= 1'b0;
			done       <= 1'b0;
		end else begin
			state      <= state_nxt;
			bus.tx_req <= send;
			done       <= (state == frame_pkg::TX_CLOSE2) && bus.tx_done;
			if (start)
				idx <= '0;
			else if (send_pay)
				idx <= idx + 1'b1;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (start) begin
			str_q <= str;
			// Lengths above the payload limit are clipped
			len_q <= (length > frame_pkg::len_t'(frame_pkg::MAX_LEN)) ?
				frame_pkg::len_t'(frame_pkg::MAX_LEN) : length;
		end
		if (send)
			bus.tx_data <= send_data;
	end

endmodule

/* hw/frame/frame_rx.sv */
/*
 * Receive string framer
 * Hunts for the '&&' opening, packs payload bytes into a working string and
 * publishes string and length on the closing '&&'
 */
`timescale 1ns/100ps

module frame_rx (
	input  logic            sys_clk,
	input  logic            sys_rst_n,
	uart_byte_if.framer_rx  bus,
	output frame_pkg::str_t str,
	output frame_pkg::len_t length,
	output logic            busy,
	output logic            done
);

	frame_pkg::rx_state_t state;
	frame_pkg::rx_state_t state_nxt;
	frame_pkg::str_t      work;
	frame_pkg::len_t      cnt;	// Bytes stored so far in this frame
	frame_pkg::len_t      cnt_sum;
	frame_pkg::len_t      cnt_nxt;
	frame_pkg::len_t      byte_pos;
	logic                 is_mark;
	logic                 clr;
	logic                 st_mark;
	logic                 st_byte;
	logic                 finish;

	assign is_mark = (bus.rx_data == frame_pkg::MARK);
	assign busy    = (state == frame_pkg::RX_BODY) || (state == frame_pkg::RX_CLOSE);
	assign clr     = bus.rx_vld && is_mark && (state == frame_pkg::RX_OPEN);
	assign finish  = bus.rx_vld && is_mark && (state == frame_pkg::RX_CLOSE);

	// A held marker followed by a normal byte stores both
	assign st_mark  = bus.rx_vld && !is_mark && (state == frame_pkg::RX_CLOSE);
	assign st_byte  = bus.rx_vld && !is_mark && busy;
	assign byte_pos = st_mark ? cnt + 1'b1 : cnt;

	assign cnt_sum = cnt + frame_pkg::len_t'(st_mark) + frame_pkg::len_t'(st_byte);
	assign cnt_nxt = (cnt_sum > frame_pkg::len_t'(frame_pkg::MAX_LEN)) ?
		frame_pkg::len_t'(frame_pkg::MAX_LEN) : cnt_sum;

	always_comb begin
		state_nxt = state;
		if (bus.rx_vld) begin
			case (state)
				frame_pkg::RX_HUNT:  if (is_mark) state_nxt = frame_pkg::RX_OPEN;
				frame_pkg::RX_OPEN:  state_nxt = is_mark ? frame_pkg::RX_BODY : frame_pkg::RX_HUNT;
				frame_pkg::RX_BODY:  if (is_mark) state_nxt = frame_pkg::RX_CLOSE;
				frame_pkg::RX_CLOSE: state_nxt = is_mark ? frame_pkg::RX_HUNT : frame_pkg::RX_BODY;
				default:             state_nxt = frame_pkg::RX_HUNT;
			endcase
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state  <= frame_pkg::RX_HUNT;
			cnt    <= '0;
			str    <= '0;
			length <= '0;
			done   <= 1'b0;
		end else begin
			state <= state_nxt;
			done  <= finish;
			if (clr)
				cnt <= '0;
			else
				cnt <= cnt_nxt;
			if (finish) begin	// Outputs hold until the next frame ends
				str    <= work;
				length <= cnt;
			end
		end
	end

	// Bytes past MAX_LEN match no slot and are dropped
	always_ff @(posedge sys_clk) begin
		for (int i = 0; i < frame_pkg::MAX_LEN; i++) begin
			if (clr) begin
				work[8*i +: 8] <= '0;
			end else begin
				if (st_mark && cnt == frame_pkg::len_t'(i))
					work[8*i +: 8] <= frame_pkg::MARK;
				if (st_byte && byte_pos == frame_pkg::len_t'(i))
					work[8*i +: 8] <= bus.rx_data;
			end
		end
	end

endmodule

/* hw/uart_string_top.sv */
/*
 * UART string transceiver top level
 * Framers and 8N1 engines joined by one byte link interface
 */
`timescale 1ns/100ps

module uart_string_top (
	input  logic            sys_clk,
	input  logic            sys_rst_n,
	input  frame_pkg::str_t tx_string,
	input  frame_pkg::len_t tx_length,
	input  logic            tx_req,
	output logic            tx_busy,
	output logic            tx_done,
	output frame_pkg::str_t rx_string,
	output frame_pkg::len_t rx_length,
	output logic            rx_busy,
	output logic            rx_done,
	input  logic            uart_rxd,
	output logic            uart_txd
);

	uart_byte_if i_byte_if ();

	frame_tx i_frame_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.req       (tx_req),
		.str       (tx_string),
		.length    (tx_length),
		.busy      (tx_busy),
		.done      (tx_done),
		.bus       (i_byte_if.framer_tx)
	);

	uart_tx i_uart_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.bus       (i_byte_if.ser_tx),
		.txd       (uart_txd)
	);

	uart_rx i_uart_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rxd       (uart_rxd),
		.bus       (i_byte_if.ser_rx)
	);

	frame_rx i_frame_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.bus       (i_byte_if.framer_rx),
		.str       (rx_string),
		.length    (rx_length),
		.busy      (rx_busy),
		.done      (rx_done)
	);

endmodule

/* dv/uart_string_props.sv */
/*
 * Protocol assertions for the UART string transceiver
 * Done pulse width, idle line level and byte request spacing
 */
`timescale 1ns/100ps

module uart_string_props (
	input logic sys_clk,
	input logic sys_rst_n,
	input logic tx_busy,
	input logic tx_done,
	input logic rx_done,
	input logic uart_txd,
	input logic byte_req,
	input logic ser_busy
);

	int fail_cnt = 0;	// Failed assertions, read by the testbench at the end of the run

	tx_done_pulse: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_done |=> !tx_done) else begin
		$error("tx_done stayed high for more than one cycle");
		fail_cnt++;
	end

	rx_done_pulse: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_done |=> !rx_done) else begin
		$error("rx_done stayed high for more than one cycle");
		fail_cnt++;
	end

	// Line must sit at the stop level whenever no frame is going out
	idle_line_high: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!tx_busy |-> uart_txd) else begin
		$error("uart_txd low while the transmit side is idle");
		fail_cnt++;
	end

	req_while_idle: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		byte_req |-> !ser_busy) else begin
		$error("byte request issued while uart_tx is mid-byte");
		fail_cnt++;
	end

endmodule

bind uart_string_top uart_string_props i_uart_string_props (
	.sys_clk   (sys_clk),
	.sys_rst_n (sys_rst_n),
	.tx_busy   (tx_busy),
	.tx_done   (tx_done),
	.rx_done   (rx_done),
	.uart_txd  (uart_txd),
	.byte_req  (i_byte_if.tx_req),
	.ser_busy  (i_uart_tx.busy)
);

/* dv/tb_uart_string.sv */
/*
 * Testbench for the UART string transceiver
 * Loopback and serializer-driven frames from an LFSR, checked against a byte queue model
 */
`timescale 1ns/100ps

module tb_uart_string;

	localparam int RST_CYCLES   = 16;
	localparam int BYTE_CYCLES  = uart_pkg::FRAME_BITS * uart_pkg::CLKS_PER_BIT;
	localparam int N_LOOP       = 20;
	localparam int CTRL_LEN     = 5;
	localparam int N_GARBAGE    = 6;
	localparam int LONG_LEN     = 20;
	localparam int LONE_LEN     = 5;
	localparam int QUIET_CYCLES = 4 * BYTE_CYCLES;

	logic            sys_clk = 1'b0;
	logic            sys_rst_n;
	frame_pkg::str_t tx_string;
	frame_pkg::len_t tx_length;
	logic            tx_req;
	logic            tx_busy;
	logic            tx_done;
	frame_pkg::str_t rx_string;
	frame_pkg::len_t rx_length;
	logic            rx_busy;
	logic            rx_done;
	logic            uart_rxd;
	logic            uart_txd;
	logic            rxd_sel;	// 0 loops uart_txd back, 1 takes the serializer
	logic            ser_rxd;

	logic [15:0]     lfsr = 16'd37301;
	int              rx_done_cnt = 0;
	uart_pkg::byte_t body_q[$];	// Payload bytes in line order
	frame_pkg::str_t got_str_q[$];
	frame_pkg::len_t got_len_q[$];
	frame_pkg::str_t exp_str;
	frame_pkg::len_t exp_len;

	always #20 sys_clk = ~sys_clk;

	assign uart_rxd = rxd_sel ? ser_rxd : uart_txd;

	uart_string_top i_uart_string_top (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_string (tx_string),
		.tx_length (tx_length),
		.tx_req    (tx_req),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.rx_string (rx_string),
		.rx_length (rx_length),
		.rx_busy   (rx_busy),
		.rx_done   (rx_done),
		.uart_rxd  (uart_rxd),
		.uart_txd  (uart_txd)
	);

	// Every received frame is queued for the checker
	always @(posedge sys_clk) begin
		if (rx_done) begin
			got_str_q.push_back(rx_string);
			got_len_q.push_back(rx_length);
			rx_done_cnt++;
		end
	end

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};	// Taps 16, 14, 13, 11
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic uart_pkg::byte_t rand_payload_byte();
		uart_pkg::byte_t b;
		b = uart_pkg::byte_t'(rand_bits(8));
		while (b == frame_pkg::MARK)
			b = uart_pkg::byte_t'(rand_bits(8));
		return b;
	endfunction

	function automatic int frame_budget(input int len);
		return (len + 6) * BYTE_CYCLES * 2;
	endfunction

	// Bytes above the payload get random filler, they must never reach the line
	function automatic frame_pkg::str_t pack_tx_string();
		frame_pkg::str_t s;
		s = '0;
		for (int i = 0; i < frame_pkg::MAX_LEN; i++)
			s[8*i +: 8] = (i < body_q.size()) ? body_q[i] : uart_pkg::byte_t'(rand_bits(8));
		return s;
	endfunction

	task automatic fill_body(input int len);
		body_q.delete();
		repeat (len) body_q.push_back(rand_payload_byte());
	endtask

	task automatic build_expected();
		int n;
		bit ended;
		n = 0;
		ended = 1'b0;
		exp_str = '0;
		for (int i = 0; i < body_q.size() && !ended; i++) begin
			// Two markers in a row end the payload, a lone one is plain data
			if (body_q[i] == frame_pkg::MARK && i + 1 < body_q.size() &&
				body_q[i + 1] == frame_pkg::MARK) begin
				ended = 1'b1;
			end else if (n < frame_pkg::MAX_LEN) begin
				exp_str[8*n +: 8] = body_q[i];
				n++;
			end
		end
		exp_len = frame_pkg::len_t'(n);
	endtask

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_str(input string name, input frame_pkg::str_t got,
		input frame_pkg::str_t exp);
		if (got !== exp)
			report_failure($sformatf("error %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_len(input string name, input frame_pkg::len_t got,
		input frame_pkg::len_t exp);
		if (got !== exp)
			report_failure($sformatf("error %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			report_failure($sformatf("error %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	// Busy must stay high until the done pulse and drop with it
	task automatic wait_tx_done();
		@(posedge sys_clk);
		while (!tx_done) begin
			check_flag("tx_busy", tx_busy, 1'b1);
			@(posedge sys_clk);
		end
		check_flag("tx_busy", tx_busy, 1'b0);
	endtask

	task automatic send_frame(input bit extra_req);
		int len;
		len = body_q.size();
		tx_string <= pack_tx_string();
		tx_length <= frame_pkg::len_t'(len);
		tx_req    <= 1'b1;
		@(posedge sys_clk);
		tx_req <= 1'b0;
		check_flag("tx_busy", tx_busy, 1'b0);
		@(posedge sys_clk);
		check_flag("tx_busy", tx_busy, 1'b1);	// One cycle after the request
		if (extra_req) begin
			tx_string <= '1;	// Must not replace the captured string
			tx_length <= frame_pkg::len_t'(frame_pkg::MAX_LEN);
			tx_req    <= 1'b1;
			@(posedge sys_clk);
			tx_req <= 1'b0;
			check_flag("tx_busy", tx_busy, 1'b1);
		end
		wait_tx_done();
	endtask

	task automatic serial_send_byte(input uart_pkg::byte_t b);
		logic [uart_pkg::FRAME_BITS-1:0] bits;
		bits = {1'b1, b, 1'b0};
		for (int i = 0; i < uart_pkg::FRAME_BITS; i++) begin
			ser_rxd <= bits[i];
			repeat (uart_pkg::CLKS_PER_BIT) @(posedge sys_clk);
		end
	endtask

	// The receiver turns busy only once the second opening marker is in
	task automatic send_serial_frame();
		check_flag("rx_busy", rx_busy, 1'b0);
		serial_send_byte(frame_pkg::MARK);
		check_flag("rx_busy", rx_busy, 1'b0);
		serial_send_byte(frame_pkg::MARK);
		check_flag("rx_busy", rx_busy, 1'b1);
		foreach (body_q[i])
			serial_send_byte(body_q[i]);
		serial_send_byte(frame_pkg::MARK);
		serial_send_byte(frame_pkg::MARK);
	endtask

	task automatic check_rx_result();
		while (got_len_q.size() == 0)
			@(posedge sys_clk);
		check_str("rx_string", got_str_q.pop_front(), exp_str);
		check_len("rx_length", got_len_q.pop_front(), exp_len);
	endtask

	initial begin
		int budget;
		budget = RST_CYCLES + N_LOOP * frame_budget(frame_pkg::MAX_LEN) + frame_budget(0) +
			frame_budget(CTRL_LEN) + QUIET_CYCLES +
			frame_budget(N_GARBAGE + 2 + LONG_LEN) + frame_budget(LONE_LEN);
		repeat (budget) @(posedge sys_clk);
		report_failure($sformatf("timeout: the run did not finish within %0d clock cycles",
			budget));
	end

	initial begin
		int rx_seen;
		sys_rst_n = 1'b0;
		tx_string = '0;
		tx_length = '0;
		tx_req    = 1'b0;
		rxd_sel   = 1'b0;
		ser_rxd   = 1'b1;
		repeat (RST_CYCLES) @(posedge sys_clk);
		sys_rst_n <= 1'b1;
		@(posedge sys_clk);

		check_flag("tx_busy", tx_busy, 1'b0);
		check_flag("tx_done", tx_done, 1'b0);
		check_flag("rx_busy", rx_busy, 1'b0);
		check_flag("rx_done", rx_done, 1'b0);
		check_flag("uart_txd", uart_txd, 1'b1);
		check_len("rx_length", rx_length, '0);
		check_str("rx_string", rx_string, '0);

		for (int f = 0; f < N_LOOP; f++) begin
			fill_body(int'(rand_bits(4)) + 1);
			build_expected();
			send_frame(1'b0);
			check_rx_result();
		end

		fill_body(0);	// Empty payload still sends four markers
		build_expected();
		send_frame(1'b0);
		check_rx_result();

		fill_body(CTRL_LEN);
		build_expected();
		rx_seen = rx_done_cnt;
		send_frame(1'b1);
		repeat (QUIET_CYCLES) begin
			@(posedge sys_clk);
			check_flag("tx_busy", tx_busy, 1'b0);
		end
		if (rx_done_cnt - rx_seen != 1)
			report_failure($sformatf(
				"expected one received frame after a request while busy, saw %0d",
				rx_done_cnt - rx_seen));
		check_rx_result();

		rxd_sel <= 1'b1;
		@(posedge sys_clk);
		repeat (N_GARBAGE) serial_send_byte(rand_payload_byte());
		serial_send_byte(frame_pkg::MARK);	// Lone marker ahead of the frame
		serial_send_byte(rand_payload_byte());
		fill_body(LONG_LEN);
		build_expected();
		send_serial_frame();
		check_rx_result();

		body_q.delete();
		body_q.push_back(rand_payload_byte());
		body_q.push_back(rand_payload_byte());
		body_q.push_back(frame_pkg::MARK);
		body_q.push_back(8'h41);	// 'A' after a lone marker keeps both
		body_q.push_back(rand_payload_byte());
		build_expected();
		send_serial_frame();
		check_rx_result();

		if (i_uart_string_top.i_uart_string_props.fail_cnt == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

/* vlog.f */
common/uart_pkg.sv
common/frame_pkg.sv
common/uart_byte_if.sv
hw/uart/uart_tx.sv
hw/uart/uart_rx.sv
hw/frame/frame_tx.sv
hw/frame/frame_rx.sv
hw/uart_string_top.sv
dv/uart_string_props.sv
dv/tb_uart_string.sv

/* run_sim.sh */
#!/bin/sh
# Builds the UART string testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f vlog.f --top-module tb_uart_string \
	-Mdir obj_dir -o sim_uart_string &&
./obj_dir/sim_uart_string | grep "SIMULATION PASSED" ||
{ echo "run_sim: build failed or no pass line in the simulation output" >&2; exit 1; }
